// ==== tb.f ====
+incdir+rtl
rtl/lsu_op_pkg.sv
rtl/lsu_bus_pkg.sv
rtl/lsu_addr_phase.sv
rtl/lsu_txn_ctrl.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
test/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_op_pkg.sv
      - rtl/lsu_bus_pkg.sv
      - rtl/lsu_addr_phase.sv
      - rtl/lsu_txn_ctrl.sv
      - rtl/lsu_rdata_align.sv
      - rtl/lsu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/lsu_tb.sv

// ==== test/lsu_tb.sv ====
/*
 * LSU testbench
 * Random loads and stores against a word memory model with grant
 * stalls and delayed responses, checked by a byte-level reference
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_tb
  import lsu_op_pkg::*, lsu_bus_pkg::*;
();

  localparam int          NUM_OPS        = 400;
  localparam int          RESET_CYCLES   = 4;
  localparam int          GNT_WAIT_MAX   = 3;
  localparam int          RESP_DELAY_MAX = 3;
  // Each bus part may wait for its grant and its response
  localparam int          CYC_PER_OP     = `LSU_DEPTH * (GNT_WAIT_MAX + 1 + RESP_DELAY_MAX) + 2;
  localparam int          MAX_CYCLES     = NUM_OPS * CYC_PER_OP + RESET_CYCLES + 16;
  localparam logic [31:0] REGION_BASE    = 32'h0001_0000;

  logic                   clk;
  logic                   rst_n;
  logic                   valid_0_i;
  logic [`LSU_DATA_W-1:0] operand_a_i;
  logic [`LSU_DATA_W-1:0] operand_b_i;
  logic [`LSU_DATA_W-1:0] wdata_i;
  logic                   we_i;
  lsu_size_e              size_i;
  logic                   sext_i;
  logic                   ready_0_o;
  logic                   split_0_o;
  logic                   valid_1_o;
  logic [`LSU_DATA_W-1:0] rdata_1_o;
  logic                   busy_o;
  logic                   req_o;
  logic                   gnt_i;
  logic [`LSU_ADDR_W-1:0] addr_o;
  logic                   we_o;
  lsu_be_t                be_o;
  logic [`LSU_DATA_W-1:0] wdata_o;
  logic                   rvalid_i;
  logic [`LSU_DATA_W-1:0] rdata_i;

  // Pre-drawn operations
  logic      we_a   [NUM_OPS];
  lsu_size_e size_a [NUM_OPS];
  logic      sext_a [NUM_OPS];
  logic [5:0] word_a [NUM_OPS];
  logic [1:0] off_a  [NUM_OPS];
  logic [31:0] wdata_a [NUM_OPS];
  logic      gap_a  [NUM_OPS];

  logic [15:0] lfsr_state;
  int          op_idx;
  int          cycle;
  int          stall_cnt;
  int          outstanding;
  int          op_grants;
  int          op_splits;

  // Bus memory and its byte-level shadow
  logic [31:0] mem [64];
  logic [7:0]  shadow [256];
  logic [31:0] resp_data_q [$];
  int          resp_due_q [$];

  // Results still owed to the core, oldest first
  logic        exp_load_q [$];
  logic [31:0] exp_data_q [$];
  logic [7:0]  exp_addr_q [$];

  lsu_top lsu_top_i
  (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .valid_0_i   ( valid_0_i   ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .wdata_i     ( wdata_i     ),
    .we_i        ( we_i        ),
    .size_i      ( size_i      ),
    .sext_i      ( sext_i      ),
    .ready_0_o   ( ready_0_o   ),
    .split_0_o   ( split_0_o   ),
    .valid_1_o   ( valid_1_o   ),
    .rdata_1_o   ( rdata_1_o   ),
    .busy_o      ( busy_o      ),
    .req_o       ( req_o       ),
    .gnt_i       ( gnt_i       ),
    .addr_o      ( addr_o      ),
    .we_o        ( we_o        ),
    .be_o        ( be_o        ),
    .wdata_o     ( wdata_o     ),
    .rvalid_i    ( rvalid_i    ),
    .rdata_i     ( rdata_i     )
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic int size_bytes(input lsu_size_e s);
    case (s)
      LSU_SIZE_BYTE: return 1;
      LSU_SIZE_HALF: return 2;
      default:       return 4;
    endcase
  endfunction

  // Initial memory contents depend on every address bit
  function automatic logic [31:0] word_fill(input int i);
    return (32'h9E37_79B9 * (i + 1)) ^ {i[7:0], ~i[7:0], i[7:0], 8'h5A};
  endfunction

  // Expected little-endian load result from the shadow
  function automatic logic [31:0] ref_load(input logic [7:0] a, input lsu_size_e s,
                                           input logic sext);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < size_bytes(s); i++)
    begin
      v[8*i +: 8] = shadow[8'(a + i)];
    end
    if (sext && s == LSU_SIZE_BYTE && v[7])
      v[31:8] = '1;
    if (sext && s == LSU_SIZE_HALF && v[15])
      v[31:16] = '1;
    return v;
  endfunction

  task automatic store_shadow(input logic [7:0] a, input lsu_size_e s, input logic [31:0] d);
    for (int i = 0; i < size_bytes(s); i++)
    begin
      shadow[8'(a + i)] = d[8*i +: 8];
    end
  endtask

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, cycle count and timeout
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES)
      stop_run($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
  end

  //////////////////////////////////////////////////////////////////////
  // Core-side driver
  //////////////////////////////////////////////////////////////////////

  // Hold each access until ready_0_o and sometimes leave one idle cycle
  always @(posedge clk)
  begin
    if (rst_n && (!valid_0_i || ready_0_o))
    begin
      if (op_idx < NUM_OPS && !(valid_0_i && gap_a[op_idx]))
      begin
        valid_0_i   <= 1'b1;
        operand_a_i <= REGION_BASE + {word_a[op_idx], 2'b00};
        operand_b_i <= {30'd0, off_a[op_idx]};
        wdata_i     <= wdata_a[op_idx];
        we_i        <= we_a[op_idx];
        size_i      <= size_a[op_idx];
        sext_i      <= sext_a[op_idx];
        op_idx      <= op_idx + 1;
      end
      else
      begin
        valid_0_i <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [5:0] idx;
    logic [1:0] dly;
    logic       stall;
    if (rst_n)
    begin
      // Stores take effect and loads read at the grant
      if (req_o && gnt_i)
      begin
        idx = addr_o[7:2];
        if (we_o)
        begin
          for (int k = 0; k < 4; k++)
          begin
            if (be_o[k])
              mem[idx][8*k +: 8] = wdata_o[8*k +: 8];
          end
        end
        dly = 2'(rand_bits(2));
        resp_data_q.push_back(mem[idx]);
        // Delay of 1 to 3 cycles after the grant
        resp_due_q.push_back(cycle + ((dly == 2'd0) ? 0 : dly - 1));
      end

      // In-order responses, one per cycle
      rvalid_i <= 1'b0;
      if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle)
      begin
        rvalid_i <= 1'b1;
        rdata_i  <= resp_data_q.pop_front();
        void'(resp_due_q.pop_front());
      end

      stall     = (rand_bits(2) == 0) && (stall_cnt < GNT_WAIT_MAX);
      gnt_i     <= !stall;
      stall_cnt = stall ? stall_cnt + 1 : 0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [7:0] byte_addr;
    int         n_parts;
    logic       is_load;
    logic [31:0] exp;
    logic [7:0]  exp_addr;
    if (rst_n)
    begin
      if (req_o && gnt_i)
      begin
        op_grants++;
        outstanding++;
        if (split_0_o)
          op_splits++;
      end
      if (rvalid_i)
        outstanding--;
      assert (outstanding <= `LSU_DEPTH)
      else stop_run($sformatf("More than %0d bus requests were waiting for a response at %0t ns",
                              `LSU_DEPTH, $time));

      // Result of the oldest access
      if (valid_1_o)
      begin
        assert (exp_load_q.size() > 0)
        else stop_run("valid_1_o rose with no access waiting for its result");
        is_load  = exp_load_q.pop_front();
        exp      = exp_data_q.pop_front();
        exp_addr = exp_addr_q.pop_front();
        if (is_load)
        begin
          assert (rdata_1_o == exp)
          else stop_run($sformatf("MISMATCH at %0t ns: load at 0x%02h expected 0x%08h got 0x%08h",
                                  $time, exp_addr, exp, rdata_1_o));
        end
      end

      // Access left the address phase
      if (ready_0_o)
      begin
        byte_addr = operand_a_i[7:0] + operand_b_i[7:0];
        // Two parts when the access runs past the end of its word
        n_parts = ((byte_addr[1:0] + size_bytes(size_i)) > 4) ? 2 : 1;
        assert (op_grants == n_parts && op_splits == n_parts - 1)
        else stop_run($sformatf("MISMATCH at %0t ns: access at 0x%02h expected %0d parts got %0d",
                                $time, byte_addr, n_parts, op_grants));
        if (we_i)
        begin
          store_shadow(byte_addr, size_i, wdata_i);
          exp_data_q.push_back(32'd0);
        end
        else
        begin
          exp_data_q.push_back(ref_load(byte_addr, size_i, sext_i));
        end
        exp_load_q.push_back(!we_i);
        exp_addr_q.push_back(byte_addr);
        op_grants = 0;
        op_splits = 0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [1:0] sz;
    rst_n       = 1'b0;
    valid_0_i   = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    wdata_i     = '0;
    we_i        = 1'b0;
    size_i      = LSU_SIZE_BYTE;
    sext_i      = 1'b0;
    gnt_i       = 1'b0;
    rvalid_i    = 1'b0;
    rdata_i     = '0;
    lfsr_state  = 16'd61576;
    op_idx      = 0;
    cycle       = 0;
    stall_cnt   = 0;
    outstanding = 0;
    op_grants   = 0;
    op_splits   = 0;

    for (int i = 0; i < 64; i++)
    begin
      mem[i] = word_fill(i);
    end
    for (int b = 0; b < 256; b++)
    begin
      shadow[b] = mem[b / 4][8*(b % 4) +: 8];
    end

    // Size code 3 is folded onto word
    for (int i = 0; i < NUM_OPS; i++)
    begin
      we_a[i]    = 1'(rand_bits(1));
      sz         = 2'(rand_bits(2));
      size_a[i]  = (sz == 2'd3) ? LSU_SIZE_WORD : lsu_size_e'(sz);
      sext_a[i]  = 1'(rand_bits(1));
      word_a[i]  = 6'(rand_bits(6));
      off_a[i]   = 2'(rand_bits(2));
      wdata_a[i] = rand_bits(32);
      gap_a[i]   = 1'(rand_bits(1));
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // All accesses issued and every response returned
    while (!(op_idx == NUM_OPS && !valid_0_i && outstanding == 0 && exp_load_q.size() == 0))
      @(posedge clk);
    @(posedge clk);
    assert (!busy_o)
    else stop_run("busy_o stayed high after all responses had returned");

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
/*
 * Load/store unit top level
 * Connects address phase, transaction control and read alignment
 * to the core pipeline and the request/grant memory bus
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_top
  import lsu_op_pkg::*, lsu_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // Core, address phase
  input  logic                   valid_0_i,
  input  logic [`LSU_DATA_W-1:0] operand_a_i,
  input  logic [`LSU_DATA_W-1:0] operand_b_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  input  logic                   we_i,
  input  lsu_size_e              size_i,
  input  logic                   sext_i,
  output logic                   ready_0_o,
  output logic                   split_0_o,
  // Core, response phase
  output logic                   valid_1_o,
  output logic [`LSU_DATA_W-1:0] rdata_1_o,
  output logic                   busy_o,
  // Memory bus
  output logic                   req_o,
  input  logic                   gnt_i,
  output logic [`LSU_ADDR_W-1:0] addr_o,
  output logic                   we_o,
  output lsu_be_t                be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o,
  input  logic                   rvalid_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i
);

  logic       ex_done;
  lsu_size_e  size_q;
  logic [1:0] offset_q;
  logic       sext_q;
  logic       we_q;
  logic       split_q;

  lsu_addr_phase addr_phase_i
  (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .valid_0_i   ( valid_0_i   ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .wdata_i     ( wdata_i     ),
    .we_i        ( we_i        ),
    .sext_i      ( sext_i      ),
    .size_i      ( size_i      ),
    .ex_done_i   ( ex_done     ),
    .addr_o      ( addr_o      ),
    .be_o        ( be_o        ),
    .wdata_o     ( wdata_o     ),
    .we_o        ( we_o        ),
    .split_o     ( split_0_o   ),
    .size_q_o    ( size_q      ),
    .offset_q_o  ( offset_q    ),
    .sext_q_o    ( sext_q      ),
    .we_q_o      ( we_q        ),
    .split_q_o   ( split_q     )
  );

  lsu_txn_ctrl txn_ctrl_i
  (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .valid_0_i ( valid_0_i ),
    .split_i   ( split_0_o ),
    .gnt_i     ( gnt_i     ),
    .rvalid_i  ( rvalid_i  ),
    .req_o     ( req_o     ),
    .ready_0_o ( ready_0_o ),
    .ex_done_o ( ex_done   ),
    .valid_1_o ( valid_1_o ),
    .busy_o    ( busy_o    )
  );

  lsu_rdata_align rdata_align_i
  (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .rvalid_i   ( rvalid_i  ),
    .rdata_i    ( rdata_i   ),
    .size_q_i   ( size_q    ),
    .offset_q_i ( offset_q  ),
    .sext_q_i   ( sext_q    ),
    .we_q_i     ( we_q      ),
    .split_q_i  ( split_q   ),
    .split_i    ( split_0_o ),
    .rdata_1_o  ( rdata_1_o )
  );

endmodule

`default_nettype wire

// ==== rtl/lsu_rdata_align.sv ====
/*
 * LSU read data alignment
 * Merges the two parts of a split load, extracts the addressed
 * byte or halfword and extends it to a full word
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_rdata_align
  import lsu_op_pkg::*, lsu_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rvalid_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  input  lsu_size_e              size_q_i,
  input  logic [1:0]             offset_q_i,
  input  logic                   sext_q_i,
  input  logic                   we_q_i,
  input  logic                   split_q_i,
  input  logic                   split_i,
  output logic [`LSU_DATA_W-1:0] rdata_1_o
);

  lsu_word_u              resp_u;
  lsu_word_u              first_q;
  logic                   split_acc;
  logic [`LSU_DATA_W-1:0] word;
  logic [15:0]            half;
  logic [7:0]             byte_sel;

  assign resp_u = rdata_i;

  // Stage-1 access spans two bus words
  always_comb
  begin
    case (size_q_i)
      LSU_SIZE_WORD: split_acc = (offset_q_i != 2'b00);
      LSU_SIZE_HALF: split_acc = (offset_q_i == 2'b11);
      default:       split_acc = 1'b0;
    endcase
  end

  // Lower part of a split load
  always_ff @(posedge clk)
  begin
    if (rvalid_i && !we_q_i && split_acc)
    begin
      first_q <= resp_u;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane selection
  //////////////////////////////////////////////////////////////////////

  // Upper lanes of the first word, then low lanes of the second
  always_comb
  begin
    case (offset_q_i)
      2'b01:   word = {resp_u.b[0], first_q.b[3:1]};
      2'b10:   word = {resp_u.h[0], first_q.h[1]};
      2'b11:   word = {resp_u.b[2:0], first_q.b[3]};
      default: word = resp_u;
    endcase
  end

  always_comb
  begin
    case (offset_q_i)
      2'b01:   half = resp_u.b[2:1];
      2'b10:   half = resp_u.h[1];
      2'b11:   half = {resp_u.b[0], first_q.b[3]};
      default: half = resp_u.h[0];
    endcase
  end

  assign byte_sel = resp_u.b[offset_q_i];

  // Sign or zero extension
  always_comb
  begin
    case (size_q_i)
      LSU_SIZE_BYTE: rdata_1_o = {{(`LSU_DATA_W-8){sext_q_i && byte_sel[7]}}, byte_sel};
      LSU_SIZE_HALF: rdata_1_o = {{(`LSU_DATA_W-16){sext_q_i && half[15]}}, half};
      default:       rdata_1_o = word;
    endcase
  end

  // Once a first part is granted stage 1 holds that split access
  assert property (@(posedge clk) disable iff (!rst_n) split_i ##1 split_q_i |-> split_acc);

endmodule

`default_nettype wire

// ==== rtl/lsu_txn_ctrl.sv ====
/*
 * LSU transaction control
 * Counts outstanding bus transactions, gates the request and
 * generates the address-phase and response-phase handshakes
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_txn_ctrl
(
  input  logic clk,
  input  logic rst_n,
  input  logic valid_0_i,
  input  logic split_i,
  input  logic gnt_i,
  input  logic rvalid_i,
  output logic req_o,
  output logic ready_0_o,
  output logic ex_done_o,
  output logic valid_1_o,
  output logic busy_o
);

  logic [1:0] cnt_q;
  logic [1:0] cnt_d;
  logic       count_up;
  logic       count_down;
  logic       last_q;
  logic       stage1_free;

  // Stage 1 holds the control of one access
  // The second part of a split shares it with the first part
  // Any other access waits until the older response returns
  assign stage1_free = (cnt_q == 2'd0) || !last_q || rvalid_i;

  assign req_o     = valid_0_i && (cnt_q < `LSU_DEPTH) && stage1_free;
  assign ex_done_o = req_o && gnt_i;

  // Core is released on the grant of the last part only
  assign ready_0_o = ex_done_o && !split_i;

  // First part of a split load stays internal
  assign valid_1_o = rvalid_i && last_q;

  assign busy_o = (cnt_q != 2'd0) || req_o;

  //////////////////////////////////////////////////////////////////////
  // Outstanding transaction counter
  //////////////////////////////////////////////////////////////////////

  assign count_up   = ex_done_o;
  assign count_down = rvalid_i;

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q  <= 2'd0;
      last_q <= 1'b1;
    end
    else
    begin
      cnt_q <= cnt_d;
      // Cleared by a granted first part, set again by its response
      if (ex_done_o && split_i)
      begin
        last_q <= 1'b0;
      end
      else if (rvalid_i)
      begin
        last_q <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) rvalid_i |-> cnt_q != 2'd0);

  // No wrap below zero
  assert property (@(posedge clk) disable iff (!rst_n) cnt_q == 2'd0 |=> cnt_q <= 2'd1);

  assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= `LSU_DEPTH);

endmodule

`default_nettype wire

// ==== rtl/lsu_addr_phase.sv ====
/*
 * LSU address phase
 * Forms the bus address, byte enables and lane-rotated store data,
 * splits misaligned accesses into two parts and captures stage-1 control
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_addr_phase
  import lsu_op_pkg::*, lsu_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // Core request
  input  logic                   valid_0_i,
  input  logic [`LSU_DATA_W-1:0] operand_a_i,
  input  logic [`LSU_DATA_W-1:0] operand_b_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  input  logic                   we_i,
  input  logic                   sext_i,
  input  lsu_size_e              size_i,
  input  logic                   ex_done_i,
  // Bus request fields
  output logic [`LSU_ADDR_W-1:0] addr_o,
  output lsu_be_t                be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o,
  output logic                   we_o,
  output logic                   split_o,
  // Control for the response stage
  output lsu_size_e              size_q_o,
  output logic [1:0]             offset_q_o,
  output logic                   sext_q_o,
  output logic                   we_q_o,
  output logic                   split_q_o
);

  logic [`LSU_ADDR_W-1:0] addr;
  logic [1:0]             offset;
  logic                   split_q;
  lsu_be_t                be_mask;
  logic [7:0]             be_wide;
  lsu_word_u              wdata_u;
  lsu_word_u              wdata_rot;

  // Base plus offset
  assign addr   = operand_a_i + operand_b_i;
  assign offset = addr[1:0];

  // Words off a word boundary and halfwords at offset 3 need two parts
  always_comb
  begin
    split_o = 1'b0;
    if (valid_0_i && !split_q)
    begin
      case (size_i)
        LSU_SIZE_WORD: split_o = (offset != 2'b00);
        LSU_SIZE_HALF: split_o = (offset == 2'b11);
        default:       split_o = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request fields
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      LSU_SIZE_BYTE: be_mask = 4'b0001;
      LSU_SIZE_HALF: be_mask = 4'b0011;
      default:       be_mask = 4'b1111;
    endcase
  end

  // Enables over this word and the next one
  // The upper lanes are what the second part still has to write
  assign be_wide = {4'b0000, be_mask} << offset;
  assign be_o    = split_q ? be_wide[7:4] : be_wide[3:0];

  // Second part goes to the next aligned word
  assign addr_o = split_q ? {addr[`LSU_ADDR_W-1:2] + 1'b1, 2'b00} : addr;
  assign we_o   = we_i;

  // Rotate store data so byte 0 lands on the addressed lane
  assign wdata_u = wdata_i;

  always_comb
  begin
    for (int i = 0; i < $bits(lsu_be_t); i++)
    begin
      wdata_rot.b[i] = wdata_u.b[2'(i - offset)];
    end
  end

  assign wdata_o = wdata_rot;

  //////////////////////////////////////////////////////////////////////
  // Split tracking and stage-1 control
  //////////////////////////////////////////////////////////////////////

  // High while the second part of a split is in the address phase
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      split_q <= 1'b0;
    end
    else if (!valid_0_i)
    begin
      split_q <= 1'b0;
    end
    else if (ex_done_i)
    begin
      split_q <= split_o;
    end
  end

  assign split_q_o = split_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q_o   <= LSU_SIZE_BYTE;
      offset_q_o <= 2'b00;
      sext_q_o   <= 1'b0;
      we_q_o     <= 1'b0;
    end
    else if (ex_done_i)
    begin
      size_q_o   <= size_i;
      offset_q_o <= offset;
      sext_q_o   <= sext_i;
      we_q_o     <= we_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lsu_bus_pkg.sv ====
/*
 * LSU memory bus types
 * Byte enables and the data word as seen in byte lanes
 */
`default_nettype none
`include "lsu_settings.svh"

package lsu_bus_pkg;

  // One enable bit per byte lane
  typedef logic [`LSU_DATA_W/8-1:0] lsu_be_t;

  // One bus word seen as byte lanes or as halfwords
  // Store data rotation works on bytes
  // Load extraction picks bytes or halfwords from the same word
  typedef union packed
  {
    logic [`LSU_DATA_W/8-1:0][7:0]   b;
    logic [`LSU_DATA_W/16-1:0][15:0] h;
  } lsu_word_u;

endpackage

`default_nettype wire

// ==== rtl/lsu_op_pkg.sv ====
/*
 * LSU operation types
 * Access size encoding of load and store instructions
 */
`default_nettype none

package lsu_op_pkg;

  // Access size as decoded by the core
  // Encoding matches funct3[1:0] of RV32 loads and stores
  typedef enum logic [1:0]
  {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10
  } lsu_size_e;

endpackage

`default_nettype wire

// ==== rtl/lsu_settings.svh ====
/*
 * LSU build settings
 * Word and address widths and the outstanding-transaction limit
 */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Data word width in bits
`define LSU_DATA_W 32

// Byte address width in bits
`define LSU_ADDR_W 32

// Maximum number of bus transactions awaiting a response
`define LSU_DEPTH 2

`endif
